//--- rtl/fpss_macros.svh
// fpss macros: widths, F-extension encodings and CSR addresses
`ifndef FPSS_MACROS_SVH
`define FPSS_MACROS_SVH

`define FPSS_XLEN    32
`define FPSS_ID_W    4
`define FPSS_NUM_FPR 32

`define FPSS_OPC_OP_FP  7'b1010011
`define FPSS_OPC_SYSTEM 7'b1110011

`define FPSS_F7_FSGNJ  7'b0010000
`define FPSS_F7_FCMP   7'b1010000
`define FPSS_F7_FMV_XW 7'b1110000
`define FPSS_F7_FMV_WX 7'b1111000

`define FPSS_F3_FSGNJ  3'b000
`define FPSS_F3_FSGNJN 3'b001
`define FPSS_F3_FSGNJX 3'b010
`define FPSS_F3_FLE    3'b000
`define FPSS_F3_FLT    3'b001
`define FPSS_F3_FEQ    3'b010
`define FPSS_F3_FMV    3'b000
`define FPSS_F3_FCLASS 3'b001
`define FPSS_F3_CSRRW  3'b001
`define FPSS_F3_CSRRS  3'b010
`define FPSS_F3_CSRRC  3'b011

`define FPSS_CSR_FFLAGS 12'h001
`define FPSS_CSR_FRM    12'h002
`define FPSS_CSR_FCSR   12'h003

`endif

//--- rtl/fpss_pkg.sv
// fpss package: instruction views, issue and result records, internal operations
`include "fpss_macros.svh"

package fpss_pkg;

  // R-type layout of an OP-FP word
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  // I-type layout used by the Zicsr instructions
  typedef struct packed {
    logic [11:0] csr_addr;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_csr_t;

  typedef union packed {
    instr_r_t   r;
    instr_csr_t csr;
  } instr_u;

  typedef struct packed {
    instr_u                  instr;
    logic [`FPSS_XLEN-1:0]   rs_val;
    logic [`FPSS_ID_W-1:0]   id;
  } issue_req_t;

  typedef struct packed {
    logic accept;
    logic writeback;
  } issue_resp_t;

  typedef enum logic [3:0] {
    OP_MV_WX,
    OP_MV_XW,
    OP_SGNJ,
    OP_SGNJN,
    OP_SGNJX,
    OP_FEQ,
    OP_FLT,
    OP_FLE,
    OP_CLASS,
    OP_CSRRW,
    OP_CSRRS,
    OP_CSRRC
  } fpss_op_e;

  typedef struct packed {
    fpss_op_e              op;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [1:0]            csr_addr;
    logic                  fp_we;
    logic                  int_we;
    logic [`FPSS_ID_W-1:0] id;
  } dec_t;

  typedef struct packed {
    logic [`FPSS_ID_W-1:0] id;
    logic [4:0]            rd;
    logic [`FPSS_XLEN-1:0] data;
    logic                  we;
  } result_t;

  // IEEE 754 exception flags in fflags bit order
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fflags_t;

endpackage

//--- rtl/fpss_decoder.sv
// fpss decoder: maps an issued word onto an internal operation and accept/writeback flags
`timescale 1ns/1ps
`include "fpss_macros.svh"

module fpss_decoder (
  input  fpss_pkg::issue_req_t  issue_req_i,
  output fpss_pkg::dec_t        dec_o,
  output fpss_pkg::issue_resp_t issue_resp_o
);

  fpss_pkg::instr_u   instr;
  fpss_pkg::fpss_op_e op;
  logic               accept;
  logic               fp_dst;

  assign instr = issue_req_i.instr;

  always_comb begin
    op     = fpss_pkg::OP_MV_WX;
    accept = 1'b0;
    case (instr.r.opcode)
      `FPSS_OPC_OP_FP: begin
        accept = 1'b1;
        case (instr.r.funct7)
          `FPSS_F7_FSGNJ: begin
            case (instr.r.funct3)
              `FPSS_F3_FSGNJ:  op = fpss_pkg::OP_SGNJ;
              `FPSS_F3_FSGNJN: op = fpss_pkg::OP_SGNJN;
              `FPSS_F3_FSGNJX: op = fpss_pkg::OP_SGNJX;
              default:         accept = 1'b0;
            endcase
          end
          `FPSS_F7_FCMP: begin
            case (instr.r.funct3)
              `FPSS_F3_FEQ: op = fpss_pkg::OP_FEQ;
              `FPSS_F3_FLT: op = fpss_pkg::OP_FLT;
              `FPSS_F3_FLE: op = fpss_pkg::OP_FLE;
              default:      accept = 1'b0;
            endcase
          end
          `FPSS_F7_FMV_XW: begin
            case (instr.r.funct3)
              `FPSS_F3_FMV:    op = fpss_pkg::OP_MV_XW;
              `FPSS_F3_FCLASS: op = fpss_pkg::OP_CLASS;
              default:         accept = 1'b0;
            endcase
            // single-source forms need rs2 = 0
            if (instr.r.rs2 != 5'd0) begin
              accept = 1'b0;
            end
          end
          `FPSS_F7_FMV_WX: begin
            op = fpss_pkg::OP_MV_WX;
            if ((instr.r.funct3 != `FPSS_F3_FMV) || (instr.r.rs2 != 5'd0)) begin
              accept = 1'b0;
            end
          end
          default: accept = 1'b0;
        endcase
      end
      `FPSS_OPC_SYSTEM: begin
        // only fflags, frm and fcsr live here
        accept = (instr.csr.csr_addr == `FPSS_CSR_FFLAGS) ||
                 (instr.csr.csr_addr == `FPSS_CSR_FRM) ||
                 (instr.csr.csr_addr == `FPSS_CSR_FCSR);
        case (instr.csr.funct3)
          `FPSS_F3_CSRRW: op = fpss_pkg::OP_CSRRW;
          `FPSS_F3_CSRRS: op = fpss_pkg::OP_CSRRS;
          `FPSS_F3_CSRRC: op = fpss_pkg::OP_CSRRC;
          default:        accept = 1'b0;
        endcase
      end
      default: accept = 1'b0;
    endcase
  end

  // moves into the FP file and sign injection return nothing to the core
  assign fp_dst = (op == fpss_pkg::OP_MV_WX) || (op == fpss_pkg::OP_SGNJ) ||
                  (op == fpss_pkg::OP_SGNJN) || (op == fpss_pkg::OP_SGNJX);

  assign dec_o.op       = op;
  assign dec_o.rd       = instr.r.rd;
  assign dec_o.rs1      = instr.r.rs1;
  assign dec_o.rs2      = instr.r.rs2;
  assign dec_o.csr_addr = instr.csr.csr_addr[1:0];
  assign dec_o.fp_we    = accept & fp_dst;
  assign dec_o.int_we   = accept & ~fp_dst;
  assign dec_o.id       = issue_req_i.id;

  assign issue_resp_o.accept    = accept;
  assign issue_resp_o.writeback = accept & ~fp_dst;

endmodule

//--- rtl/fpss_regfile.sv
// fpss register file: 32 single-precision registers, two async read ports, one write port
`timescale 1ns/1ps
`include "fpss_macros.svh"

module fpss_regfile (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic [4:0]            raddr_a_i,
  input  logic [4:0]            raddr_b_i,
  output logic [`FPSS_XLEN-1:0] rdata_a_o,
  output logic [`FPSS_XLEN-1:0] rdata_b_o,
  input  logic [4:0]            waddr_i,
  input  logic [`FPSS_XLEN-1:0] wdata_i,
  input  logic                  we_i
);

  logic [`FPSS_XLEN-1:0] regs_q [`FPSS_NUM_FPR];

  // f0 is an ordinary register, unlike x0
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `FPSS_NUM_FPR; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

//--- rtl/fpss_csr.sv
// fpss CSR block: fflags and frm with Zicsr read-modify-write and NV accumulation
`timescale 1ns/1ps
`include "fpss_macros.svh"

module fpss_csr (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  fpss_pkg::fpss_op_e    csr_op_i,
  input  logic [1:0]            csr_addr_i,
  input  logic [`FPSS_XLEN-1:0] wdata_i,
  input  logic                  csr_en_i,
  input  logic                  nv_set_i,
  output logic [`FPSS_XLEN-1:0] rdata_o
);

  fpss_pkg::fflags_t     fflags_q;
  logic [2:0]            frm_q;
  logic [`FPSS_XLEN-1:0] new_val;
  logic                  wr_fflags;
  logic                  wr_frm;

  // old value of the addressed register
  always_comb begin
    case (csr_addr_i)
      2'd1:    rdata_o = {27'd0, fflags_q};
      2'd2:    rdata_o = {29'd0, frm_q};
      2'd3:    rdata_o = {24'd0, frm_q, fflags_q};
      default: rdata_o = '0;
    endcase
  end

  always_comb begin
    case (csr_op_i)
      fpss_pkg::OP_CSRRW: new_val = wdata_i;
      fpss_pkg::OP_CSRRS: new_val = rdata_o | wdata_i;
      fpss_pkg::OP_CSRRC: new_val = rdata_o & ~wdata_i;
      default:            new_val = rdata_o;
    endcase
  end

  // fcsr touches both fields
  assign wr_fflags = csr_en_i && (csr_addr_i == 2'd1 || csr_addr_i == 2'd3);
  assign wr_frm    = csr_en_i && (csr_addr_i == 2'd2 || csr_addr_i == 2'd3);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fflags_q <= '0;
      frm_q    <= '0;
    end else begin
      if (wr_fflags) begin
        fflags_q <= new_val[4:0];
      end else if (nv_set_i) begin
        fflags_q.nv <= 1'b1;
      end
      if (wr_frm) begin
        frm_q <= (csr_addr_i == 2'd3) ? new_val[7:5] : new_val[2:0];
      end
    end
  end

endmodule

//--- rtl/fpss_execute.sv
// fpss execute: moves, sign injection, compares and fclass, with FP file and CSR updates
`timescale 1ns/1ps
`include "fpss_macros.svh"

module fpss_execute (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  fpss_pkg::dec_t        dec_i,
  input  logic [`FPSS_XLEN-1:0] rs_val_i,
  input  logic                  exec_en_i,
  output fpss_pkg::result_t     exec_res_o
);

  logic [`FPSS_XLEN-1:0] op_a;
  logic [`FPSS_XLEN-1:0] op_b;
  logic [`FPSS_XLEN-1:0] csr_rdata;
  logic [`FPSS_XLEN-1:0] res_data;
  logic [9:0]            class_a;
  logic [9:0]            class_b;
  logic                  nan_any;
  logic                  snan_any;
  logic                  both_zero;
  logic                  cmp_eq;
  logic                  cmp_lt;
  logic                  is_cmp;
  logic                  is_csr;
  logic                  nv;

  // standard fclass one-hot, bit 0 is -inf and bit 9 is quiet NaN
  function automatic logic [9:0] fclass_f(input logic [`FPSS_XLEN-1:0] v);
    logic       sign;
    logic [7:0] e;
    logic [22:0] m;
    logic [9:0] c;
    sign = v[31];
    e    = v[30:23];
    m    = v[22:0];
    c    = '0;
    if (e == 8'hff) begin
      if (m == 23'd0) begin
        c[sign ? 0 : 7] = 1'b1;
      end else if (m[22]) begin
        c[9] = 1'b1;
      end else begin
        c[8] = 1'b1;
      end
    end else if (e == 8'h00) begin
      if (m == 23'd0) begin
        c[sign ? 3 : 4] = 1'b1;
      end else begin
        c[sign ? 2 : 5] = 1'b1;
      end
    end else begin
      c[sign ? 1 : 6] = 1'b1;
    end
    return c;
  endfunction

  assign class_a = fclass_f(op_a);
  assign class_b = fclass_f(op_b);

  assign nan_any   = |class_a[9:8] | |class_b[9:8];
  assign snan_any  = class_a[8] | class_b[8];
  assign both_zero = (class_a[3] | class_a[4]) & (class_b[3] | class_b[4]);

  // magnitude compare flips when both operands are negative
  always_comb begin
    cmp_eq = ~nan_any & ((op_a == op_b) | both_zero);
    if (nan_any || both_zero) begin
      cmp_lt = 1'b0;
    end else if (op_a[31] != op_b[31]) begin
      cmp_lt = op_a[31];
    end else if (op_a[31]) begin
      cmp_lt = op_a[30:0] > op_b[30:0];
    end else begin
      cmp_lt = op_a[30:0] < op_b[30:0];
    end
  end

  assign is_cmp = dec_i.op inside {fpss_pkg::OP_FEQ, fpss_pkg::OP_FLT, fpss_pkg::OP_FLE};
  assign is_csr = dec_i.op inside {fpss_pkg::OP_CSRRW, fpss_pkg::OP_CSRRS, fpss_pkg::OP_CSRRC};

  // feq is a quiet compare, flt and fle signal on any NaN
  assign nv = (dec_i.op == fpss_pkg::OP_FEQ) ? snan_any : nan_any;

  always_comb begin
    case (dec_i.op)
      fpss_pkg::OP_MV_WX: res_data = rs_val_i;
      fpss_pkg::OP_MV_XW: res_data = op_a;
      fpss_pkg::OP_SGNJ:  res_data = {op_b[31], op_a[30:0]};
      fpss_pkg::OP_SGNJN: res_data = {~op_b[31], op_a[30:0]};
      fpss_pkg::OP_SGNJX: res_data = {op_a[31] ^ op_b[31], op_a[30:0]};
      fpss_pkg::OP_FEQ:   res_data = {31'd0, cmp_eq};
      fpss_pkg::OP_FLT:   res_data = {31'd0, cmp_lt};
      fpss_pkg::OP_FLE:   res_data = {31'd0, cmp_lt | cmp_eq};
      fpss_pkg::OP_CLASS: res_data = {22'd0, class_a};
      default:            res_data = csr_rdata;
    endcase
  end

  fpss_regfile u_regfile (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .raddr_a_i (dec_i.rs1),
    .raddr_b_i (dec_i.rs2),
    .rdata_a_o (op_a),
    .rdata_b_o (op_b),
    .waddr_i   (dec_i.rd),
    .wdata_i   (res_data),
    .we_i      (exec_en_i & dec_i.fp_we)
  );

  fpss_csr u_csr (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .csr_op_i   (dec_i.op),
    .csr_addr_i (dec_i.csr_addr),
    .wdata_i    (rs_val_i),
    .csr_en_i   (exec_en_i & is_csr),
    .nv_set_i   (exec_en_i & is_cmp & nv),
    .rdata_o    (csr_rdata)
  );

  assign exec_res_o.id   = dec_i.id;
  assign exec_res_o.rd   = dec_i.rd;
  assign exec_res_o.data = res_data;
  assign exec_res_o.we   = dec_i.int_we;

endmodule

//--- rtl/fpss_result.sv
// fpss result stage: single result holding register with issue back-pressure
`timescale 1ns/1ps

module fpss_result (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              issue_valid_i,
  input  logic              accept_i,
  input  fpss_pkg::result_t exec_res_i,
  output logic              issue_ready_o,
  output logic              exec_en_o,
  output logic              result_valid_o,
  output fpss_pkg::result_t result_o,
  input  logic              result_ready_i
);

  logic              valid_q;
  fpss_pkg::result_t result_q;

  // free slot, or the held result leaves this cycle
  assign issue_ready_o = ~valid_q | result_ready_i;

  // rejected transfers are consumed without touching state
  assign exec_en_o = issue_valid_i & issue_ready_o & accept_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (exec_en_o) begin
      valid_q <= 1'b1;
    end else if (result_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exec_en_o) begin
      result_q <= exec_res_i;
    end
  end

  assign result_valid_o = valid_q;
  assign result_o       = result_q;

endmodule

//--- rtl/fpss_top.sv
// fpss top: F-extension coprocessor with issue and result handshakes
`timescale 1ns/1ps

module fpss_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  x_issue_valid_i,
  input  fpss_pkg::issue_req_t  x_issue_req_i,
  output logic                  x_issue_ready_o,
  output fpss_pkg::issue_resp_t x_issue_resp_o,
  output logic                  result_valid_o,
  output fpss_pkg::result_t     result_o,
  input  logic                  result_ready_i
);

  fpss_pkg::dec_t    dec;
  fpss_pkg::result_t exec_res;
  logic              exec_en;

  fpss_decoder u_decoder (
    .issue_req_i  (x_issue_req_i),
    .dec_o        (dec),
    .issue_resp_o (x_issue_resp_o)
  );

  fpss_execute u_execute (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .dec_i      (dec),
    .rs_val_i   (x_issue_req_i.rs_val),
    .exec_en_i  (exec_en),
    .exec_res_o (exec_res)
  );

  // accept is combinational from the request, so it qualifies this cycle's transfer
  fpss_result u_result (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .issue_valid_i  (x_issue_valid_i),
    .accept_i       (x_issue_resp_o.accept),
    .exec_res_i     (exec_res),
    .issue_ready_o  (x_issue_ready_o),
    .exec_en_o      (exec_en),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .result_ready_i (result_ready_i)
  );

endmodule

//--- sim/fpss_tb_clkgen.sv
// fpss testbench clock and reset: 10 ns clock, reset held low for two cycles
`timescale 1ns/1ps

module fpss_tb_clkgen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

//--- sim/fpss_properties.sv
// fpss handshake properties: result hold under back-pressure, reset state, issue stall
`timescale 1ns/1ps

module fpss_properties (
  input logic              clk_i,
  input logic              arst_n_i,
  input logic              issue_ready_i,
  input logic              result_valid_i,
  input fpss_pkg::result_t result_i,
  input logic              result_ready_i
);

  int unsigned fail_count;

  initial begin
    fail_count = 0;
  end

  // a pending result may not change or vanish until it is taken
  hold_result: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_valid_i && !result_ready_i |=> result_valid_i && $stable(result_i))
  else begin
    fail_count++;
    $error("result changed or dropped while result_ready_i was low");
  end

  reset_clear: assert property (@(posedge clk_i) $rose(arst_n_i) |-> !result_valid_i)
  else begin
    fail_count++;
    $error("result_valid_o high right after reset");
  end

  // one result slot, so a stuck result blocks issue
  issue_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_valid_i && !result_ready_i |-> !issue_ready_i)
  else begin
    fail_count++;
    $error("x_issue_ready_o high while a held result is not taken");
  end

endmodule

//--- sim/fpss_tb.sv
// fpss testbench with directed tests of moves, sign injection, compares, fclass and CSR access
`timescale 1ns/1ps
`include "fpss_macros.svh"

module fpss_tb;

  localparam int timeout_cycles = 50;

  logic                  clk;
  logic                  arst_n;
  logic                  issue_valid;
  fpss_pkg::issue_req_t  issue_req;
  logic                  issue_ready;
  fpss_pkg::issue_resp_t issue_resp;
  logic                  result_valid;
  fpss_pkg::result_t     result;
  logic                  result_ready;

  logic [3:0]            next_id;
  logic [3:0]            cur_id;
  // expected CSR contents
  logic [4:0]            model_fflags;
  logic [2:0]            model_frm;

  fpss_tb_clkgen u_clkgen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  fpss_top dut0 (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .x_issue_valid_i (issue_valid),
    .x_issue_req_i   (issue_req),
    .x_issue_ready_o (issue_ready),
    .x_issue_resp_o  (issue_resp),
    .result_valid_o  (result_valid),
    .result_o        (result),
    .result_ready_i  (result_ready)
  );

  bind fpss_result fpss_properties u_props (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .issue_ready_i  (issue_ready_o),
    .result_valid_i (result_valid_o),
    .result_i       (result_o),
    .result_ready_i (result_ready_i)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_result(input fpss_pkg::result_t got, input fpss_pkg::result_t exp,
                              input string what);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s result %p, expected %p", $time, what, got, exp));
    end
  endtask

  task automatic check_resp(input fpss_pkg::issue_resp_t got,
                            input fpss_pkg::issue_resp_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s response %p, expected %p", $time, what, got, exp));
    end
  endtask

  task automatic check_props();
    if (dut0.u_result.u_props.fail_count != 0) begin
      stop_run("handshake assertion failed");
    end
  endtask

  function automatic logic [31:0] op_fp(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    fpss_pkg::instr_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = `FPSS_OPC_OP_FP;
    return w;
  endfunction

  function automatic logic [31:0] csr_word(input logic [2:0] f3, input logic [11:0] addr);
    fpss_pkg::instr_u w;
    w.csr.csr_addr = addr;
    w.csr.rs1      = 5'd1;
    w.csr.funct3   = f3;
    w.csr.rd       = 5'd5;
    w.csr.opcode   = `FPSS_OPC_SYSTEM;
    return w;
  endfunction

  // {nv, result} for feq/flt/fle by IEEE ordering with -0 and +0 on one key
  function automatic logic [1:0] cmp_model(input logic [2:0] f3, input logic [31:0] a,
                                           input logic [31:0] b);
    logic   a_nan;
    logic   b_nan;
    logic   snan;
    logic   res;
    logic   nv;
    longint ka;
    longint kb;
    a_nan = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
    b_nan = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
    snan  = (a_nan && !a[22]) || (b_nan && !b[22]);
    ka    = a[30:0];
    kb    = b[30:0];
    if (a[31]) ka = -ka;
    if (b[31]) kb = -kb;
    if (a_nan || b_nan) begin
      res = 1'b0;
    end else if (f3 == `FPSS_F3_FEQ) begin
      res = (ka == kb);
    end else if (f3 == `FPSS_F3_FLT) begin
      res = (ka < kb);
    end else begin
      res = (ka <= kb);
    end
    nv = (f3 == `FPSS_F3_FEQ) ? snan : (a_nan || b_nan);
    return {nv, res};
  endfunction

  task automatic drive_issue(input logic [31:0] word, input logic [31:0] opnd);
    @(posedge clk);
    cur_id = next_id;
    next_id = next_id + 4'd1;
    issue_valid <= 1'b1;
    issue_req   <= {word, opnd, cur_id};
  endtask

  // response is sampled mid-cycle and the transfer happens at the following edge
  task automatic finish_issue(output fpss_pkg::issue_resp_t resp);
    int n;
    n = 0;
    @(negedge clk);
    while (!issue_ready) begin
      n++;
      if (n > timeout_cycles) stop_run("timeout waiting for x_issue_ready_o");
      @(negedge clk);
    end
    resp = issue_resp;
    @(posedge clk);
    issue_valid <= 1'b0;
  endtask

  task automatic wait_result(output fpss_pkg::result_t res);
    int n;
    n = 0;
    @(negedge clk);
    while (!result_valid) begin
      n++;
      if (n > timeout_cycles) stop_run("timeout waiting for result_valid_o");
      @(negedge clk);
    end
    res = result;
  endtask

  task automatic run_checked(input logic [31:0] word, input logic [31:0] opnd, input logic wb,
                             input logic [31:0] exp_data, input string what);
    fpss_pkg::issue_resp_t resp;
    fpss_pkg::issue_resp_t exp_resp;
    fpss_pkg::result_t     res;
    fpss_pkg::result_t     exp_res;
    drive_issue(word, opnd);
    finish_issue(resp);
    exp_resp.accept    = 1'b1;
    exp_resp.writeback = wb;
    check_resp(resp, exp_resp, what);
    wait_result(res);
    exp_res.id   = cur_id;
    exp_res.rd   = word[11:7];
    exp_res.data = exp_data;
    exp_res.we   = wb;
    check_result(res, exp_res, what);
  endtask

  task automatic write_fpr(input logic [4:0] rd, input logic [31:0] v);
    run_checked(op_fp(`FPSS_F7_FMV_WX, `FPSS_F3_FMV, rd, 5'd0, 5'd0), v, 1'b0, v, "fmv.w.x");
  endtask

  task automatic expect_fpr(input logic [4:0] rs, input logic [31:0] v);
    run_checked(op_fp(`FPSS_F7_FMV_XW, `FPSS_F3_FMV, 5'd10, rs, 5'd0), '0, 1'b1, v, "fmv.x.w");
  endtask

  task automatic csr_access(input logic [2:0] f3, input logic [11:0] addr,
                            input logic [31:0] opnd);
    logic [31:0] old;
    logic [31:0] upd;
    case (addr)
      `FPSS_CSR_FFLAGS: old = {27'd0, model_fflags};
      `FPSS_CSR_FRM:    old = {29'd0, model_frm};
      default:          old = {24'd0, model_frm, model_fflags};
    endcase
    case (f3)
      `FPSS_F3_CSRRW: upd = opnd;
      `FPSS_F3_CSRRS: upd = old | opnd;
      default:        upd = old & ~opnd;
    endcase
    run_checked(csr_word(f3, addr), opnd, 1'b1, old,
                $sformatf("csr %03h funct3 %0d", addr, f3));
    case (addr)
      `FPSS_CSR_FFLAGS: model_fflags = upd[4:0];
      `FPSS_CSR_FRM:    model_frm = upd[2:0];
      default: begin
        model_frm    = upd[7:5];
        model_fflags = upd[4:0];
      end
    endcase
  endtask

  task automatic issue_rejected(input logic [31:0] word, input logic [31:0] opnd);
    fpss_pkg::issue_resp_t resp;
    fpss_pkg::issue_resp_t exp_resp;
    exp_resp = '0;
    drive_issue(word, opnd);
    finish_issue(resp);
    check_resp(resp, exp_resp, "unsupported instruction");
    repeat (3) begin
      @(negedge clk);
      if (result_valid) stop_run("a rejected instruction produced a result");
    end
  endtask

  task automatic test_moves();
    logic [31:0] vals [8];
    for (int i = 0; i < 8; i++) begin
      vals[i] = $urandom;
      write_fpr(5'(i * 4), vals[i]);
    end
    for (int i = 0; i < 8; i++) begin
      expect_fpr(5'(i * 4), vals[i]);
    end
  endtask

  task automatic test_sign_inject();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    logic [2:0]  f3;
    for (int n = 0; n < 4; n++) begin
      a = $urandom;
      b = $urandom;
      write_fpr(5'd1, a);
      write_fpr(5'd2, b);
      for (int k = 0; k < 3; k++) begin
        case (k)
          0: begin
            f3  = `FPSS_F3_FSGNJ;
            exp = {b[31], a[30:0]};
          end
          1: begin
            f3  = `FPSS_F3_FSGNJN;
            exp = {~b[31], a[30:0]};
          end
          default: begin
            f3  = `FPSS_F3_FSGNJX;
            exp = {a[31] ^ b[31], a[30:0]};
          end
        endcase
        run_checked(op_fp(`FPSS_F7_FSGNJ, f3, 5'd3, 5'd1, 5'd2), '0, 1'b0, exp, "sign injection");
        expect_fpr(5'd3, exp);
      end
    end
  endtask

  task automatic test_compares();
    logic [31:0] vals [8];
    logic [2:0]  f3s [3];
    logic [1:0]  m;
    // +0, -0, 1.0, -1.0, 2.0, qNaN, sNaN, -inf
    vals = '{32'h00000000, 32'h80000000, 32'h3f800000, 32'hbf800000,
             32'h40000000, 32'h7fc00000, 32'h7f800001, 32'hff800000};
    f3s  = '{`FPSS_F3_FEQ, `FPSS_F3_FLT, `FPSS_F3_FLE};
    for (int i = 0; i < 8; i++) begin
      write_fpr(5'(i + 1), vals[i]);
    end
    csr_access(`FPSS_F3_CSRRW, `FPSS_CSR_FFLAGS, '0);
    for (int k = 0; k < 3; k++) begin
      for (int i = 0; i < 8; i++) begin
        for (int j = 0; j < 8; j++) begin
          m = cmp_model(f3s[k], vals[i], vals[j]);
          run_checked(op_fp(`FPSS_F7_FCMP, f3s[k], 5'd12, 5'(i + 1), 5'(j + 1)), '0, 1'b1,
                      {31'd0, m[0]},
                      $sformatf("compare f3 %0d %08h %08h", f3s[k], vals[i], vals[j]));
          if (m[1]) model_fflags = model_fflags | 5'h10;
          csr_access(`FPSS_F3_CSRRS, `FPSS_CSR_FFLAGS, '0);
          csr_access(`FPSS_F3_CSRRW, `FPSS_CSR_FFLAGS, '0);
        end
      end
    end
  endtask

  task automatic test_fclass();
    logic [31:0] vals [11];
    int          bits [11];
    vals = '{32'h00000000, 32'h80000000, 32'h00000001, 32'h80400000, 32'h3f800000,
             32'hc0000000, 32'h7f800000, 32'hff800000, 32'h7fc00000, 32'h7f800001,
             32'hffc00001};
    bits = '{4, 3, 5, 2, 6, 1, 7, 0, 9, 8, 9};
    for (int i = 0; i < 11; i++) begin
      write_fpr(5'd9, vals[i]);
      run_checked(op_fp(`FPSS_F7_FMV_XW, `FPSS_F3_FCLASS, 5'd10, 5'd9, 5'd0), '0, 1'b1,
                  32'd1 << bits[i], $sformatf("fclass %08h", vals[i]));
    end
  endtask

  task automatic test_csr();
    csr_access(`FPSS_F3_CSRRW, `FPSS_CSR_FRM, $urandom & 32'h7);
    csr_access(`FPSS_F3_CSRRS, `FPSS_CSR_FRM, 32'h4);
    csr_access(`FPSS_F3_CSRRC, `FPSS_CSR_FRM, 32'h1);
    csr_access(`FPSS_F3_CSRRW, `FPSS_CSR_FFLAGS, 32'h15);
    csr_access(`FPSS_F3_CSRRS, `FPSS_CSR_FFLAGS, 32'h0a);
    csr_access(`FPSS_F3_CSRRC, `FPSS_CSR_FFLAGS, 32'h03);
    csr_access(`FPSS_F3_CSRRS, `FPSS_CSR_FCSR, '0);
    csr_access(`FPSS_F3_CSRRW, `FPSS_CSR_FCSR, 32'ha5);
    csr_access(`FPSS_F3_CSRRC, `FPSS_CSR_FCSR, 32'h21);
    csr_access(`FPSS_F3_CSRRS, `FPSS_CSR_FRM, '0);
    csr_access(`FPSS_F3_CSRRS, `FPSS_CSR_FFLAGS, '0);
    // fadd.s and then a CSR outside the FP set
    issue_rejected(op_fp(7'b0000000, 3'b000, 5'd4, 5'd1, 5'd2), '0);
    issue_rejected(csr_word(`FPSS_F3_CSRRW, 12'h300), 32'hff);
    csr_access(`FPSS_F3_CSRRS, `FPSS_CSR_FCSR, '0);
  endtask

  task automatic test_backpressure();
    fpss_pkg::issue_resp_t resp;
    fpss_pkg::issue_resp_t exp_resp;
    fpss_pkg::result_t     held;
    fpss_pkg::result_t     exp_res;
    fpss_pkg::result_t     res;
    logic [31:0]           v;
    logic [31:0]           w;
    v = $urandom;
    w = $urandom;
    exp_resp.accept    = 1'b1;
    exp_resp.writeback = 1'b1;
    write_fpr(5'd20, v);
    write_fpr(5'd21, w);
    @(posedge clk);
    result_ready <= 1'b0;
    drive_issue(op_fp(`FPSS_F7_FMV_XW, `FPSS_F3_FMV, 5'd11, 5'd20, 5'd0), '0);
    finish_issue(resp);
    check_resp(resp, exp_resp, "first fmv.x.w");
    wait_result(held);
    exp_res.id   = cur_id;
    exp_res.rd   = 5'd11;
    exp_res.data = v;
    exp_res.we   = 1'b1;
    check_result(held, exp_res, "held result");
    // second instruction waits behind the stuck result
    drive_issue(op_fp(`FPSS_F7_FMV_XW, `FPSS_F3_FMV, 5'd12, 5'd21, 5'd0), '0);
    repeat (4) begin
      @(negedge clk);
      if (!result_valid) stop_run("result_valid_o dropped while result_ready_i was low");
      check_result(result, exp_res, "result under back-pressure");
      if (issue_ready) stop_run("x_issue_ready_o high while a result is held");
    end
    @(posedge clk);
    result_ready <= 1'b1;
    finish_issue(resp);
    check_resp(resp, exp_resp, "queued fmv.x.w");
    wait_result(res);
    exp_res.id   = cur_id;
    exp_res.rd   = 5'd12;
    exp_res.data = w;
    check_result(res, exp_res, "queued result");
  endtask

  initial begin
    int n;
    void'($urandom(6));
    issue_valid  = 1'b0;
    issue_req    = '0;
    result_ready = 1'b1;
    next_id      = '0;
    cur_id       = '0;
    model_fflags = '0;
    model_frm    = '0;
    n = 0;
    // reset may still be unknown in the first time step
    while (arst_n !== 1'b1) begin
      n++;
      if (n > timeout_cycles) stop_run("reset was never released");
      @(posedge clk);
    end
    test_moves();
    check_props();
    test_sign_inject();
    check_props();
    test_compares();
    check_props();
    test_fclass();
    check_props();
    test_csr();
    check_props();
    test_backpressure();
    repeat (2) @(posedge clk);
    if (dut0.u_result.u_props.fail_count != 0) begin
      stop_run("handshake assertion failed");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

//--- verilog.f
+incdir+rtl
rtl/fpss_pkg.sv
rtl/fpss_decoder.sv
rtl/fpss_regfile.sv
rtl/fpss_csr.sv
rtl/fpss_execute.sv
rtl/fpss_result.sv
rtl/fpss_top.sv
sim/fpss_tb_clkgen.sv
sim/fpss_properties.sv
sim/fpss_tb.sv
